/* logic/rsGeometryPkg.sv */
`default_nettype none

package rsGeometryPkg;

  // station depth, one entry per waiting instruction
  localparam int defaultEntryCount = 8;

  // result buses that can wake a pending operand
  localparam int defaultBroadcastCount = 2;

  // dispatch lanes are not a parameter here
  // the allocator is built for exactly two

endpackage

`default_nettype wire

/* logic/rsFieldPkg.sv */
`default_nettype none

package rsFieldPkg;

  // result tag carried on dispatch and broadcast
  localparam int tagWidth = 6;

  // operand value
  localparam int dataWidth = 32;

  // address offset held with the instruction
  localparam int constWidth = 16;

  // AGU operation code
  localparam int opWidth = 4;

endpackage

`default_nettype wire

/* logic/rsOperandSlot.sv */
`timescale 1ns/1ps
`default_nettype none

module rsOperandSlot #(
  parameter int broadcastCount = 2
) (
  input  logic                                                 clk,
  input  logic                                                 arstN,
  input  logic                                                 flush,
  input  logic                                                 load,
  input  logic                                                 needIn,
  input  logic [rsFieldPkg::tagWidth-1:0]                      tagIn,
  input  logic [rsFieldPkg::dataWidth-1:0]                     dataIn,
  input  logic [broadcastCount-1:0]                            bcValid,
  input  logic [broadcastCount-1:0][rsFieldPkg::tagWidth-1:0]  bcTag,
  input  logic [broadcastCount-1:0][rsFieldPkg::dataWidth-1:0] bcData,
  output logic                                                 present,
  output logic [rsFieldPkg::dataWidth-1:0]                     value
);

  logic                           pending;
  logic [rsFieldPkg::tagWidth-1:0]  tagQ;
  logic [rsFieldPkg::dataWidth-1:0] dataQ;
  logic [rsFieldPkg::tagWidth-1:0]  cmpTag;
  logic                           hit;
  logic [rsFieldPkg::dataWidth-1:0] hitData;

  // on load the incoming tag is compared so a same-cycle result is not missed
  assign cmpTag = load ? tagIn : tagQ;

  // walk from the top so the lowest bus wins
  always_comb begin
    hit = 1'b0;
    hitData = '0;
    for (int i = broadcastCount - 1; i >= 0; i--) begin
      if (bcValid[i] && bcTag[i] == cmpTag) begin
        hit = 1'b1;
        hitData = bcData[i];
      end
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pending <= 1'b0;
    end else if (flush) begin
      pending <= 1'b0;
    end else if (load) begin
      pending <= needIn && !hit;
    end else if (pending && hit) begin
      pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      tagQ <= tagIn;
      dataQ <= (needIn && hit) ? hitData : dataIn;
    end else if (pending && hit) begin
      dataQ <= hitData;
    end
  end

  assign present = !pending;
  assign value = dataQ;

endmodule

`default_nettype wire

/* logic/rsEntry.sv */
`timescale 1ns/1ps
`default_nettype none

module rsEntry #(
  parameter int broadcastCount = 2
) (
  input  logic                                                 clk,
  input  logic                                                 arstN,
  input  logic                                                 flush,
  input  logic                                                 load,
  input  logic                                                 laneSel,
  input  logic [rsFieldPkg::opWidth-1:0]                       dispOp0,
  input  logic [rsFieldPkg::constWidth-1:0]                    dispConst0,
  input  logic                                                 dispNeedA0,
  input  logic [rsFieldPkg::tagWidth-1:0]                      dispTagA0,
  input  logic [rsFieldPkg::dataWidth-1:0]                     dispDataA0,
  input  logic                                                 dispNeedB0,
  input  logic [rsFieldPkg::tagWidth-1:0]                      dispTagB0,
  input  logic [rsFieldPkg::dataWidth-1:0]                     dispDataB0,
  input  logic [rsFieldPkg::opWidth-1:0]                       dispOp1,
  input  logic [rsFieldPkg::constWidth-1:0]                    dispConst1,
  input  logic                                                 dispNeedA1,
  input  logic [rsFieldPkg::tagWidth-1:0]                      dispTagA1,
  input  logic [rsFieldPkg::dataWidth-1:0]                     dispDataA1,
  input  logic                                                 dispNeedB1,
  input  logic [rsFieldPkg::tagWidth-1:0]                      dispTagB1,
  input  logic [rsFieldPkg::dataWidth-1:0]                     dispDataB1,
  input  logic [broadcastCount-1:0]                            bcValid,
  input  logic [broadcastCount-1:0][rsFieldPkg::tagWidth-1:0]  bcTag,
  input  logic [broadcastCount-1:0][rsFieldPkg::dataWidth-1:0] bcData,
  input  logic                                                 take,
  output logic                                                 busy,
  output logic                                                 eligible,
  output logic [rsFieldPkg::opWidth-1:0]                       op,
  output logic [rsFieldPkg::constWidth-1:0]                    constant,
  output logic [rsFieldPkg::dataWidth-1:0]                     dataA,
  output logic [rsFieldPkg::dataWidth-1:0]                     dataB
);

  logic presentA;
  logic presentB;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      busy <= 1'b0;
    end else if (flush) begin
      busy <= 1'b0;
    end else if (load) begin
      busy <= 1'b1;
    end else if (take) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      op <= laneSel ? dispOp1 : dispOp0;
      constant <= laneSel ? dispConst1 : dispConst0;
    end
  end

  rsOperandSlot #(
    .broadcastCount(broadcastCount)
  ) i_slotA (
    .clk(clk),
    .arstN(arstN),
    .flush(flush),
    .load(load),
    .needIn(laneSel ? dispNeedA1 : dispNeedA0),
    .tagIn(laneSel ? dispTagA1 : dispTagA0),
    .dataIn(laneSel ? dispDataA1 : dispDataA0),
    .bcValid(bcValid),
    .bcTag(bcTag),
    .bcData(bcData),
    .present(presentA),
    .value(dataA)
  );

  rsOperandSlot #(
    .broadcastCount(broadcastCount)
  ) i_slotB (
    .clk(clk),
    .arstN(arstN),
    .flush(flush),
    .load(load),
    .needIn(laneSel ? dispNeedB1 : dispNeedB0),
    .tagIn(laneSel ? dispTagB1 : dispTagB0),
    .dataIn(laneSel ? dispDataB1 : dispDataB0),
    .bcValid(bcValid),
    .bcTag(bcTag),
    .bcData(bcData),
    .present(presentB),
    .value(dataB)
  );

  assign eligible = busy && presentA && presentB;

endmodule

`default_nettype wire

/* logic/rsAllocator.sv */
`timescale 1ns/1ps
`default_nettype none

module rsAllocator #(
  parameter int entryCount = 8
) (
  input  logic [entryCount-1:0] busy,
  input  logic                  flush,
  input  logic                  dispValid0,
  input  logic                  dispValid1,
  output logic                  dispReady0,
  output logic                  dispReady1,
  output logic [entryCount-1:0] load,
  output logic [entryCount-1:0] laneSel
);

  logic [entryCount-1:0] firstOh;
  logic [entryCount-1:0] secondOh;
  logic [entryCount-1:0] lane1Oh;
  logic                  firstFound;
  logic                  secondFound;
  logic                  fire0;
  logic                  fire1;

  // lowest and next-lowest free entry
  always_comb begin
    firstOh = '0;
    secondOh = '0;
    firstFound = 1'b0;
    secondFound = 1'b0;
    for (int i = 0; i < entryCount; i++) begin
      if (!busy[i]) begin
        if (!firstFound) begin
          firstFound = 1'b1;
          firstOh[i] = 1'b1;
        end else if (!secondFound) begin
          secondFound = 1'b1;
          secondOh[i] = 1'b1;
        end
      end
    end
  end

  // ready depends on free count only, never on valid
  assign dispReady0 = !flush && firstFound;
  assign dispReady1 = !flush && secondFound;

  assign fire0 = dispValid0 && dispReady0;
  assign fire1 = dispValid1 && dispReady1;

  // lane 1 alone gets the lowest slot
  assign lane1Oh = fire0 ? secondOh : firstOh;

  assign load = (fire0 ? firstOh : '0) | (fire1 ? lane1Oh : '0);
  assign laneSel = fire1 ? lane1Oh : '0;

endmodule

`default_nettype wire

/* logic/rsIssueSelect.sv */
`timescale 1ns/1ps
`default_nettype none

module rsIssueSelect #(
  parameter int entryCount = 8
) (
  input  logic                                              clk,
  input  logic                                              arstN,
  input  logic                                              flush,
  input  logic [entryCount-1:0]                             eligible,
  input  logic [entryCount-1:0][rsFieldPkg::opWidth-1:0]    entryOp,
  input  logic [entryCount-1:0][rsFieldPkg::constWidth-1:0] entryConst,
  input  logic [entryCount-1:0][rsFieldPkg::dataWidth-1:0]  entryDataA,
  input  logic [entryCount-1:0][rsFieldPkg::dataWidth-1:0]  entryDataB,
  input  logic                                              issueReady,
  output logic [entryCount-1:0]                             take,
  output logic                                              issueValid,
  output logic [rsFieldPkg::opWidth-1:0]                    issueOp,
  output logic [rsFieldPkg::constWidth-1:0]                 issueConst,
  output logic [rsFieldPkg::dataWidth-1:0]                  issueDataA,
  output logic [rsFieldPkg::dataWidth-1:0]                  issueDataB
);

  logic [entryCount-1:0]            pickOh;
  logic                             found;
  logic                             advance;
  logic [rsFieldPkg::opWidth-1:0]    selOp;
  logic [rsFieldPkg::constWidth-1:0] selConst;
  logic [rsFieldPkg::dataWidth-1:0]  selDataA;
  logic [rsFieldPkg::dataWidth-1:0]  selDataB;

  // lowest eligible index and its payload
  always_comb begin
    found = 1'b0;
    pickOh = '0;
    selOp = '0;
    selConst = '0;
    selDataA = '0;
    selDataB = '0;
    for (int i = 0; i < entryCount; i++) begin
      if (eligible[i] && !found) begin
        found = 1'b1;
        pickOh[i] = 1'b1;
        selOp = entryOp[i];
        selConst = entryConst[i];
        selDataA = entryDataA[i];
        selDataB = entryDataB[i];
      end
    end
  end

  // stage refills when empty or when its item leaves this cycle
  assign advance = !issueValid || issueReady;
  assign take = (advance && !flush) ? pickOh : '0;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      issueValid <= 1'b0;
    end else if (flush) begin
      issueValid <= 1'b0;
    end else if (advance) begin
      issueValid <= found;
    end
  end

  always_ff @(posedge clk) begin
    if (advance && found) begin
      issueOp <= selOp;
      issueConst <= selConst;
      issueDataA <= selDataA;
      issueDataB <= selDataB;
    end
  end

endmodule

`default_nettype wire

/* logic/rsStation.sv */
`timescale 1ns/1ps
`default_nettype none

module rsStation #(
  parameter int entryCount = rsGeometryPkg::defaultEntryCount,
  parameter int broadcastCount = rsGeometryPkg::defaultBroadcastCount
) (
  input  logic                                                 clk,
  input  logic                                                 arstN,
  input  logic                                                 flush,
  input  logic                                                 dispValid0,
  output logic                                                 dispReady0,
  input  logic [rsFieldPkg::opWidth-1:0]                       dispOp0,
  input  logic [rsFieldPkg::constWidth-1:0]                    dispConst0,
  input  logic                                                 dispNeedA0,
  input  logic [rsFieldPkg::tagWidth-1:0]                      dispTagA0,
  input  logic [rsFieldPkg::dataWidth-1:0]                     dispDataA0,
  input  logic                                                 dispNeedB0,
  input  logic [rsFieldPkg::tagWidth-1:0]                      dispTagB0,
  input  logic [rsFieldPkg::dataWidth-1:0]                     dispDataB0,
  input  logic                                                 dispValid1,
  output logic                                                 dispReady1,
  input  logic [rsFieldPkg::opWidth-1:0]                       dispOp1,
  input  logic [rsFieldPkg::constWidth-1:0]                    dispConst1,
  input  logic                                                 dispNeedA1,
  input  logic [rsFieldPkg::tagWidth-1:0]                      dispTagA1,
  input  logic [rsFieldPkg::dataWidth-1:0]                     dispDataA1,
  input  logic                                                 dispNeedB1,
  input  logic [rsFieldPkg::tagWidth-1:0]                      dispTagB1,
  input  logic [rsFieldPkg::dataWidth-1:0]                     dispDataB1,
  input  logic [broadcastCount-1:0]                            bcValid,
  input  logic [broadcastCount-1:0][rsFieldPkg::tagWidth-1:0]  bcTag,
  input  logic [broadcastCount-1:0][rsFieldPkg::dataWidth-1:0] bcData,
  output logic                                                 issueValid,
  input  logic                                                 issueReady,
  output logic [rsFieldPkg::opWidth-1:0]                       issueOp,
  output logic [rsFieldPkg::constWidth-1:0]                    issueConst,
  output logic [rsFieldPkg::dataWidth-1:0]                     issueDataA,
  output logic [rsFieldPkg::dataWidth-1:0]                     issueDataB
);

  logic [entryCount-1:0]                             busy;
  logic [entryCount-1:0]                             eligible;
  logic [entryCount-1:0]                             load;
  logic [entryCount-1:0]                             laneSel;
  logic [entryCount-1:0]                             take;
  logic [entryCount-1:0][rsFieldPkg::opWidth-1:0]    entryOp;
  logic [entryCount-1:0][rsFieldPkg::constWidth-1:0] entryConst;
  logic [entryCount-1:0][rsFieldPkg::dataWidth-1:0]  entryDataA;
  logic [entryCount-1:0][rsFieldPkg::dataWidth-1:0]  entryDataB;

  rsAllocator #(
    .entryCount(entryCount)
  ) i_rsAllocator (
    .busy(busy),
    .flush(flush),
    .dispValid0(dispValid0),
    .dispValid1(dispValid1),
    .dispReady0(dispReady0),
    .dispReady1(dispReady1),
    .load(load),
    .laneSel(laneSel)
  );

  // every entry sees both lanes, laneSel picks one
  for (genvar e = 0; e < entryCount; e++) begin : gEntry
    rsEntry #(
      .broadcastCount(broadcastCount)
    ) i_rsEntry (
      .clk(clk),
      .arstN(arstN),
      .flush(flush),
      .load(load[e]),
      .laneSel(laneSel[e]),
      .dispOp0(dispOp0),
      .dispConst0(dispConst0),
      .dispNeedA0(dispNeedA0),
      .dispTagA0(dispTagA0),
      .dispDataA0(dispDataA0),
      .dispNeedB0(dispNeedB0),
      .dispTagB0(dispTagB0),
      .dispDataB0(dispDataB0),
      .dispOp1(dispOp1),
      .dispConst1(dispConst1),
      .dispNeedA1(dispNeedA1),
      .dispTagA1(dispTagA1),
      .dispDataA1(dispDataA1),
      .dispNeedB1(dispNeedB1),
      .dispTagB1(dispTagB1),
      .dispDataB1(dispDataB1),
      .bcValid(bcValid),
      .bcTag(bcTag),
      .bcData(bcData),
      .take(take[e]),
      .busy(busy[e]),
      .eligible(eligible[e]),
      .op(entryOp[e]),
      .constant(entryConst[e]),
      .dataA(entryDataA[e]),
      .dataB(entryDataB[e])
    );
  end

  rsIssueSelect #(
    .entryCount(entryCount)
  ) i_rsIssueSelect (
    .clk(clk),
    .arstN(arstN),
    .flush(flush),
    .eligible(eligible),
    .entryOp(entryOp),
    .entryConst(entryConst),
    .entryDataA(entryDataA),
    .entryDataB(entryDataB),
    .issueReady(issueReady),
    .take(take),
    .issueValid(issueValid),
    .issueOp(issueOp),
    .issueConst(issueConst),
    .issueDataA(issueDataA),
    .issueDataB(issueDataB)
  );

endmodule

`default_nettype wire

/* tests/rsChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module rsChecker #(
  parameter int entryCount = 8,
  parameter int broadcastCount = 2
) (
  input  logic clk,
  input  logic arstN,
  input  logic flush,
  input  logic dispValid0, dispReady0, dispNeedA0, dispNeedB0,
  input  logic dispValid1, dispReady1, dispNeedA1, dispNeedB1,
  input  logic [rsFieldPkg::opWidth-1:0] dispOp0, dispOp1, issueOp,
  input  logic [rsFieldPkg::constWidth-1:0] dispConst0, dispConst1, issueConst,
  input  logic [rsFieldPkg::tagWidth-1:0] dispTagA0, dispTagB0, dispTagA1, dispTagB1,
  input  logic [rsFieldPkg::dataWidth-1:0] dispDataA0, dispDataB0, dispDataA1, dispDataB1,
  input  logic [broadcastCount-1:0] bcValid,
  input  logic [broadcastCount-1:0][rsFieldPkg::tagWidth-1:0] bcTag,
  input  logic [broadcastCount-1:0][rsFieldPkg::dataWidth-1:0] bcData,
  input  logic issueValid,
  input  logic issueReady,
  input  logic [rsFieldPkg::dataWidth-1:0] issueDataA, issueDataB,
  output int errorCount,
  output int checkCount,
  output int modelCount
);

  // accepted instructions share one index across all queues
  logic [rsFieldPkg::opWidth-1:0] qOp[$];
  logic [rsFieldPkg::constWidth-1:0] qConst[$];
  logic qPendA[$], qPendB[$];
  logic [rsFieldPkg::tagWidth-1:0] qTagA[$], qTagB[$];
  logic [rsFieldPkg::dataWidth-1:0] qDataA[$], qDataB[$];
  logic afterReset = 1'b1;
  logic holdPrev = 1'b0;
  logic [rsFieldPkg::opWidth-1:0] heldOp;
  logic [rsFieldPkg::constWidth-1:0] heldConst;
  logic [rsFieldPkg::dataWidth-1:0] heldDataA, heldDataB;
  int busyCount;

  initial begin
    errorCount = 0;
    checkCount = 0;
    modelCount = 0;
  end

  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    checkCount++;
    if (exp !== act) begin
      errorCount++;
      $display("FAILED %s: expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic reportError(input string msg);
    errorCount++;
    $display("%s", msg);
  endtask

  task automatic clearModel();
    qOp.delete();
    qConst.delete();
    qPendA.delete();
    qPendB.delete();
    qTagA.delete();
    qTagB.delete();
    qDataA.delete();
    qDataB.delete();
  endtask

  // lowest bus wins when two carry the tag
  task automatic lookupTag(input logic [rsFieldPkg::tagWidth-1:0] tag, output logic hit,
                           output logic [rsFieldPkg::dataWidth-1:0] data);
    hit = 1'b0;
    data = '0;
    for (int b = broadcastCount - 1; b >= 0; b--) begin
      if (bcValid[b] && bcTag[b] == tag) begin
        hit = 1'b1;
        data = bcData[b];
      end
    end
  endtask

  task automatic resolvePending();
    logic hit;
    logic [rsFieldPkg::dataWidth-1:0] data;
    for (int i = 0; i < qConst.size(); i++) begin
      if (qPendA[i]) begin
        lookupTag(qTagA[i], hit, data);
        if (hit) begin
          qPendA[i] = 1'b0;
          qDataA[i] = data;
        end
      end
      if (qPendB[i]) begin
        lookupTag(qTagB[i], hit, data);
        if (hit) begin
          qPendB[i] = 1'b0;
          qDataB[i] = data;
        end
      end
    end
  endtask

  task automatic addInstr(input logic [rsFieldPkg::opWidth-1:0] op,
                          input logic [rsFieldPkg::constWidth-1:0] cst,
                          input logic needA, input logic [rsFieldPkg::tagWidth-1:0] tagA,
                          input logic [rsFieldPkg::dataWidth-1:0] dataA,
                          input logic needB, input logic [rsFieldPkg::tagWidth-1:0] tagB,
                          input logic [rsFieldPkg::dataWidth-1:0] dataB);
    qOp.push_back(op);
    qConst.push_back(cst);
    qPendA.push_back(needA);
    qTagA.push_back(tagA);
    qDataA.push_back(dataA);
    qPendB.push_back(needB);
    qTagB.push_back(tagB);
    qDataB.push_back(dataB);
  endtask

  task automatic matchIssue();
    int hits;
    int idx;
    hits = 0;
    idx = 0;
    for (int i = 0; i < qConst.size(); i++) begin
      if (qConst[i] == issueConst && qOp[i] == issueOp) begin
        hits++;
        idx = i;
      end
    end
    checkCount++;
    if (hits != 1) begin
      reportError($sformatf("issued op %0h const %0h matches %0d accepted instructions",
                            issueOp, issueConst, hits));
    end else begin
      if (qPendA[idx] || qPendB[idx]) begin
        reportError($sformatf("const %0h issued before its operand tag was broadcast",
                              issueConst));
      end
      checkValue("issueDataA", qDataA[idx], issueDataA);
      checkValue("issueDataB", qDataB[idx], issueDataB);
      qOp.delete(idx);
      qConst.delete(idx);
      qPendA.delete(idx);
      qPendB.delete(idx);
      qTagA.delete(idx);
      qTagB.delete(idx);
      qDataA.delete(idx);
      qDataB.delete(idx);
    end
  endtask

  always @(posedge clk) begin
    if (!arstN) begin
      clearModel();
      afterReset = 1'b1;
      holdPrev = 1'b0;
    end else begin
      if (afterReset) begin
        checkValue("resetIssueValid", 32'd0, {31'd0, issueValid});
        afterReset = 1'b0;
      end
      // the item in the issue stage no longer holds an entry
      busyCount = qConst.size() - (issueValid ? 1 : 0);
      checkValue("dispReady0", {31'd0, !flush && busyCount < entryCount}, {31'd0, dispReady0});
      checkValue("dispReady1", {31'd0, !flush && busyCount <= entryCount - 2},
                 {31'd0, dispReady1});
      if (holdPrev) begin
        checkValue("holdIssueValid", 32'd1, {31'd0, issueValid});
        checkValue("holdIssueOp", {28'd0, heldOp}, {28'd0, issueOp});
        checkValue("holdIssueConst", {16'd0, heldConst}, {16'd0, issueConst});
        checkValue("holdIssueDataA", heldDataA, issueDataA);
        checkValue("holdIssueDataB", heldDataB, issueDataB);
      end
      if (issueValid && issueReady) begin
        matchIssue();
      end
      if (dispValid0 && dispReady0) begin
        addInstr(dispOp0, dispConst0, dispNeedA0, dispTagA0, dispDataA0,
                 dispNeedB0, dispTagB0, dispDataB0);
      end
      if (dispValid1 && dispReady1) begin
        addInstr(dispOp1, dispConst1, dispNeedA1, dispTagA1, dispDataA1,
                 dispNeedB1, dispTagB1, dispDataB1);
      end
      // same-edge broadcasts reach fresh dispatches too
      resolvePending();
      if (flush) begin
        clearModel();
      end
      holdPrev = issueValid && !issueReady && !flush;
      heldOp = issueOp;
      heldConst = issueConst;
      heldDataA = issueDataA;
      heldDataB = issueDataB;
    end
    modelCount = qConst.size();
  end

endmodule

`default_nettype wire

/* tests/tbRsStation.sv */
`timescale 1ns/1ps
`default_nettype none

module tbRsStation;

  localparam int entryCount = rsGeometryPkg::defaultEntryCount;
  localparam int broadcastCount = rsGeometryPkg::defaultBroadcastCount;
  localparam int stimCycles = 2000;
  localparam int cycleLimit = 10 * stimCycles;

  logic clk = 1'b0;
  logic arstN;
  logic flush;
  logic dispValid0, dispReady0, dispNeedA0, dispNeedB0;
  logic dispValid1, dispReady1, dispNeedA1, dispNeedB1;
  logic [rsFieldPkg::opWidth-1:0] dispOp0, dispOp1, issueOp;
  logic [rsFieldPkg::constWidth-1:0] dispConst0, dispConst1, issueConst;
  logic [rsFieldPkg::tagWidth-1:0] dispTagA0, dispTagB0, dispTagA1, dispTagB1;
  logic [rsFieldPkg::dataWidth-1:0] dispDataA0, dispDataB0, dispDataA1, dispDataB1;
  logic [broadcastCount-1:0] bcValid;
  logic [broadcastCount-1:0][rsFieldPkg::tagWidth-1:0] bcTag;
  logic [broadcastCount-1:0][rsFieldPkg::dataWidth-1:0] bcData;
  logic issueValid, issueReady;
  logic [rsFieldPkg::dataWidth-1:0] issueDataA, issueDataB;
  int errorCount, checkCount, modelCount;
  int cycleCount = 0;
  logic [31:0] lfsrState;
  logic [rsFieldPkg::tagWidth-1:0] outTags[$];
  logic [63:0] tagOut;
  logic [rsFieldPkg::tagWidth-1:0] nextTag;
  logic [rsFieldPkg::constWidth-1:0] constSeq;

  always #2 clk = ~clk;

  // one Galois step per random bit
  function automatic logic stepLfsr();
    logic lsb;
    lsb = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (lsb) begin
      lfsrState = lfsrState ^ 32'hA300_0000;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], stepLfsr()};
    end
    return r;
  endfunction

  // a needed operand waits on a tag that has not been broadcast yet
  task automatic pickOperand(output logic need, output logic [rsFieldPkg::tagWidth-1:0] tag,
                             output logic [rsFieldPkg::dataWidth-1:0] data);
    int idx;
    need = randBits(1) == 32'd1 && outTags.size() > 0;
    tag = '0;
    if (need) begin
      idx = int'(randBits(8)) % outTags.size();
      tag = outTags[idx];
    end
    data = randBits(32);
  endtask

  task automatic broadcastTags(input logic forceAll);
    logic [broadcastCount-1:0] v;
    logic [broadcastCount-1:0][rsFieldPkg::tagWidth-1:0] t;
    logic [broadcastCount-1:0][rsFieldPkg::dataWidth-1:0] d;
    int idx;
    v = '0;
    t = '0;
    d = '0;
    for (int b = 0; b < broadcastCount; b++) begin
      if ((forceAll || randBits(2) == 32'd0) && outTags.size() > 0) begin
        idx = int'(randBits(8)) % outTags.size();
        v[b] = 1'b1;
        t[b] = outTags[idx];
        d[b] = randBits(32);
        tagOut[outTags[idx]] = 1'b0;
        outTags.delete(idx);
      end
    end
    bcValid <= v;
    bcTag <= t;
    bcData <= d;
  endtask

  task automatic driveCycle();
    logic need;
    logic [rsFieldPkg::tagWidth-1:0] tag;
    logic [rsFieldPkg::dataWidth-1:0] data;
    logic [31:0] r;
    if (randBits(1) == 32'd1 && outTags.size() < 32) begin
      while (tagOut[nextTag]) begin
        nextTag = nextTag + 1'b1;
      end
      tagOut[nextTag] = 1'b1;
      outTags.push_back(nextTag);
    end
    dispValid0 <= randBits(2) != 32'd0;
    r = randBits(4);
    dispOp0 <= r[rsFieldPkg::opWidth-1:0];
    dispConst0 <= constSeq;
    pickOperand(need, tag, data);
    dispNeedA0 <= need;
    dispTagA0 <= tag;
    dispDataA0 <= data;
    pickOperand(need, tag, data);
    dispNeedB0 <= need;
    dispTagB0 <= tag;
    dispDataB0 <= data;
    dispValid1 <= randBits(2) != 32'd0;
    r = randBits(4);
    dispOp1 <= r[rsFieldPkg::opWidth-1:0];
    dispConst1 <= constSeq + 1'b1;
    pickOperand(need, tag, data);
    dispNeedA1 <= need;
    dispTagA1 <= tag;
    dispDataA1 <= data;
    pickOperand(need, tag, data);
    dispNeedB1 <= need;
    dispTagB1 <= tag;
    dispDataB1 <= data;
    // consts stay unique so each issue maps to one instruction
    constSeq = constSeq + 2'd2;
    broadcastTags(1'b0);
    issueReady <= randBits(2) != 32'd0;
    flush <= randBits(7) == 32'd0;
  endtask

  rsStation #(
    .entryCount(entryCount),
    .broadcastCount(broadcastCount)
  ) i_rsStation (
    .clk(clk), .arstN(arstN), .flush(flush),
    .dispValid0(dispValid0), .dispReady0(dispReady0), .dispOp0(dispOp0),
    .dispConst0(dispConst0), .dispNeedA0(dispNeedA0), .dispTagA0(dispTagA0),
    .dispDataA0(dispDataA0), .dispNeedB0(dispNeedB0), .dispTagB0(dispTagB0),
    .dispDataB0(dispDataB0),
    .dispValid1(dispValid1), .dispReady1(dispReady1), .dispOp1(dispOp1),
    .dispConst1(dispConst1), .dispNeedA1(dispNeedA1), .dispTagA1(dispTagA1),
    .dispDataA1(dispDataA1), .dispNeedB1(dispNeedB1), .dispTagB1(dispTagB1),
    .dispDataB1(dispDataB1),
    .bcValid(bcValid), .bcTag(bcTag), .bcData(bcData),
    .issueValid(issueValid), .issueReady(issueReady), .issueOp(issueOp),
    .issueConst(issueConst), .issueDataA(issueDataA), .issueDataB(issueDataB)
  );

  rsChecker #(
    .entryCount(entryCount),
    .broadcastCount(broadcastCount)
  ) i_rsChecker (
    .clk(clk), .arstN(arstN), .flush(flush),
    .dispValid0(dispValid0), .dispReady0(dispReady0), .dispOp0(dispOp0),
    .dispConst0(dispConst0), .dispNeedA0(dispNeedA0), .dispTagA0(dispTagA0),
    .dispDataA0(dispDataA0), .dispNeedB0(dispNeedB0), .dispTagB0(dispTagB0),
    .dispDataB0(dispDataB0),
    .dispValid1(dispValid1), .dispReady1(dispReady1), .dispOp1(dispOp1),
    .dispConst1(dispConst1), .dispNeedA1(dispNeedA1), .dispTagA1(dispTagA1),
    .dispDataA1(dispDataA1), .dispNeedB1(dispNeedB1), .dispTagB1(dispTagB1),
    .dispDataB1(dispDataB1),
    .bcValid(bcValid), .bcTag(bcTag), .bcData(bcData),
    .issueValid(issueValid), .issueReady(issueReady), .issueOp(issueOp),
    .issueConst(issueConst), .issueDataA(issueDataA), .issueDataB(issueDataB),
    .errorCount(errorCount), .checkCount(checkCount), .modelCount(modelCount)
  );

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: station did not drain within %0d cycles", cycleLimit);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    lfsrState = 32'd70;
    tagOut = '0;
    nextTag = '0;
    constSeq = '0;
    arstN = 1'b0;
    flush = 1'b0;
    dispValid0 = 1'b0;
    dispValid1 = 1'b0;
    dispOp0 = '0;
    dispOp1 = '0;
    dispConst0 = '0;
    dispConst1 = '0;
    dispNeedA0 = 1'b0;
    dispNeedB0 = 1'b0;
    dispNeedA1 = 1'b0;
    dispNeedB1 = 1'b0;
    dispTagA0 = '0;
    dispTagB0 = '0;
    dispTagA1 = '0;
    dispTagB1 = '0;
    dispDataA0 = '0;
    dispDataB0 = '0;
    dispDataA1 = '0;
    dispDataB1 = '0;
    bcValid = '0;
    bcTag = '0;
    bcData = '0;
    issueReady = 1'b0;
    repeat (10) @(posedge clk);
    arstN <= 1'b1;
    for (int c = 0; c < stimCycles; c++) begin
      @(posedge clk);
      driveCycle();
    end
    // drain with no dispatch, the AGU always ready and every tag resolved
    @(posedge clk);
    dispValid0 <= 1'b0;
    dispValid1 <= 1'b0;
    flush <= 1'b0;
    issueReady <= 1'b1;
    broadcastTags(1'b1);
    while (outTags.size() > 0) begin
      @(posedge clk);
      broadcastTags(1'b1);
    end
    @(posedge clk);
    bcValid <= '0;
    @(negedge clk);
    while (modelCount != 0 || issueValid) begin
      @(negedge clk);
    end
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
logic/rsGeometryPkg.sv
logic/rsFieldPkg.sv
logic/rsOperandSlot.sv
logic/rsEntry.sv
logic/rsAllocator.sv
logic/rsIssueSelect.sv
logic/rsStation.sv
tests/rsChecker.sv
tests/tbRsStation.sv

/* run.sh */
#!/bin/sh
# build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbRsStation -f vlog.f -o simv
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "^Done: no errors$" sim.log; then
  exit 0
fi
exit 1
